// File: risc_cpu.f
logic/risc_pkg.sv
logic/dp_ctrl_if.sv
logic/reg_file.sv
logic/alu_shifter.sv
logic/datapath.sv
logic/bus_unit.sv
logic/controller.sv
logic/risc_cpu.sv
verification/risc_cpu_tb.sv

// File: Bender.yml
package:
  name: risc_cpu

sources:
  # design, in compile order
  - logic/risc_pkg.sv
  - logic/dp_ctrl_if.sv
  - logic/reg_file.sv
  - logic/alu_shifter.sv
  - logic/datapath.sv
  - logic/bus_unit.sv
  - logic/controller.sv
  - logic/risc_cpu.sv

  # testbench
  - target: simulation
    files:
      - verification/risc_cpu_tb.sv

// File: verification/risc_cpu_tests.txt
# test <name> <mid-run reset 0|1> / prog <instruction words, hex> / store <addr data> pairs, hex
# flags <v n z> as three binary digits, the status expected once the program halts

# imm8 sign extension and Rn plus imm5 addressing, negative offset included
test mov_imm_str 0
prog D040 D105 D29C 8020 8043 D350 833E E000
store 40 0005 43 FF9C 4E 0005
flags 000

# add, and, add with Rm shifted left
test add_and 0
prog D040 D17F D2F0 A162 B182 A1AA 8060 8081 80A2 E000
store 40 006F 41 0070 42 005F
flags 000

# mov register with all four shift codes, mvn plain and shifted
test mov_shift_mvn 0
prog D060 D196 C041 C069 C091 C0B9 B8C1 B8F1 8040 8061 8082 80A3 80C4 80E5 E000
store 60 FF96 61 FF2C 62 7FCB 63 FFCB 64 0069 65 8034
flags 000

test cmp_zero 0
prog D070 D105 D205 A902 8020 8041 E000
store 70 0005 71 0005
flags 001

# reset hits after the compare, then the program runs again from word 0
test cmp_neg_reset 1
prog D078 D103 D205 A902 8020 8041 E000
store 78 0003 79 0005
flags 010

# 7FFF minus FFFF overflows
test cmp_ovf 0
prog D030 D1FF C071 AB01 8060 8021 E000
store 30 7FFF 31 FFFF
flags 110

// File: verification/risc_cpu_tb.sv
`timescale 1ns/1ps

module risc_cpu_tb import risc_pkg::*; ();

    localparam int cycles_per_word = 20;
    localparam int settle_cycles   = 8;

    logic              clk;
    logic              rst_n;
    logic [data_w-1:0] wb_dat_i;
    logic              wb_ack;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [addr_w-1:0] wb_adr;
    logic [data_w-1:0] wb_dat_o;
    logic              halted;
    logic [2:0]        status;

    // test table
    string             t_name [$];
    int                t_abort [$];
    int                t_prog_first [$];
    int                t_prog_cnt [$];
    int                t_store_first [$];
    int                t_store_cnt [$];
    logic [2:0]        t_flags [$];
    logic [data_w-1:0] prog_word [$];
    logic [addr_w-1:0] exp_adr [$];
    logic [data_w-1:0] exp_dat [$];

    // memory model state
    logic [data_w-1:0] mem [2**addr_w];
    logic [addr_w-1:0] seen_adr [$];
    logic [data_w-1:0] seen_dat [$];
    logic              pending;
    logic [1:0]        wait_left;
    integer            seed = 98877;
    integer            rnd;

    string             cur_test;
    int                cycle_cnt;
    int                cycle_limit;

    // bus sampled one edge earlier
    logic              rst_q;
    logic              stb_q;
    logic              ack_q;
    logic              we_q;
    logic [addr_w-1:0] adr_q;
    logic [data_w-1:0] dat_q;

    risc_cpu i_risc_cpu (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_o (wb_dat_o),
        .halted   (halted),
        .status   (status)
    );

    always #50 clk = ~clk;

    task automatic stop_on_failure();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [data_w-1:0] exp,
                                   input logic [data_w-1:0] act);
        $display("** Error: test %s, %s: expected %h, actual %h", cur_test, what, exp, act);
        stop_on_failure();
    endtask

    task automatic report_fault(input string what);
        $display("test %s: %s", cur_test, what);
        stop_on_failure();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wishbone slave memory with 0 to 3 random wait cycles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        if (!rst_n) begin
            wb_ack  <= 1'b0;
            pending <= 1'b0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_stb) begin
            if (!pending) begin
                rnd = $random(seed);
                pending   <= 1'b1;
                wait_left <= rnd[1:0];
            end else if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                pending <= 1'b0;
                wb_ack  <= 1'b1;
                if (wb_we) begin
                    mem[wb_adr] <= wb_dat_o;
                    seen_adr.push_back(wb_adr);
                    seen_dat.push_back(wb_dat_o);
                end else begin
                    wb_dat_i <= mem[wb_adr];
                end
            end
        end
    end

    // protocol monitor
    always @(posedge clk) begin
        if (rst_n && rst_q) begin
            assert (wb_cyc == wb_stb) else report_fault("cyc and stb differ");
            if (stb_q && !ack_q) begin
                assert (wb_stb) else report_fault("stb dropped before ack");
                assert (wb_adr == adr_q && wb_we == we_q)
                    else report_fault("adr or we changed while waiting for ack");
                assert (!we_q || wb_dat_o == dat_q)
                    else report_fault("write data changed while waiting for ack");
            end
            assert (!(halted && wb_stb)) else report_fault("bus cycle active after halt");
        end
        rst_q <= rst_n;
        stb_q <= wb_stb;
        ack_q <= wb_ack;
        we_q  <= wb_we;
        adr_q <= wb_adr;
        dat_q <= wb_dat_o;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycle_cnt <= cycle_cnt + 1;
        end
        assert (cycle_limit == 0 || cycle_cnt < cycle_limit) else begin
            $display("timeout: the processor never halted within %0d cycles", cycle_limit);
            stop_on_failure();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test file and test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic read_tests();
        int                fd;
        int                rc;
        int                mode;
        int                cur;
        bit                half;
        string             tok;
        string             line;
        string             name;
        int                abort_flag;
        logic [2:0]        fl;
        logic [data_w-1:0] val;
        logic [addr_w-1:0] adr;
        fd = $fopen("verification/risc_cpu_tests.txt", "r");
        assert (fd != 0) else report_fault("cannot open verification/risc_cpu_tests.txt");
        mode = 0;
        cur  = -1;
        half = 1'b0;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok[0] == "#") begin
                rc = $fgets(line, fd);
            end else if (tok == "test") begin
                rc = $fscanf(fd, "%s %d", name, abort_flag);
                t_name.push_back(name);
                t_abort.push_back(abort_flag);
                t_prog_first.push_back(prog_word.size());
                t_prog_cnt.push_back(0);
                t_store_first.push_back(exp_adr.size());
                t_store_cnt.push_back(0);
                cur  = t_name.size() - 1;
                mode = 0;
            end else if (tok == "prog") begin
                mode = 1;
            end else if (tok == "store") begin
                mode = 2;
                half = 1'b0;
            end else if (tok == "flags") begin
                rc = $fscanf(fd, "%b", fl);
                t_flags.push_back(fl);
                mode = 0;
            end else if (mode == 1) begin
                rc = $sscanf(tok, "%h", val);
                prog_word.push_back(val);
                t_prog_cnt[cur] = t_prog_cnt[cur] + 1;
            end else if (mode == 2 && !half) begin
                rc = $sscanf(tok, "%h", adr);
                exp_adr.push_back(adr);
                half = 1'b1;
            end else if (mode == 2) begin
                rc = $sscanf(tok, "%h", val);
                exp_dat.push_back(val);
                t_store_cnt[cur] = t_store_cnt[cur] + 1;
                half = 1'b0;
            end else begin
                report_fault({"unexpected token in test file: ", tok});
            end
        end
        $fclose(fd);
        assert (t_name.size() > 0 && t_flags.size() == t_name.size())
            else report_fault("test file holds no complete test");
    endtask

    task automatic load_memory(input int t);
        int a;
        for (a = 0; a < 2**addr_w; a++) begin
            mem[a] = {a[7:0] ^ 8'hc3, a[7:0]};
        end
        for (a = 0; a < t_prog_cnt[t]; a++) begin
            mem[a] = prog_word[t_prog_first[t] + a];
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        assert (!wb_cyc && !wb_stb && !wb_we) else report_fault("bus signals active in reset");
        assert (!halted) else report_fault("halted high in reset");
        assert (status == 3'b000)
            else report_mismatch("status in reset", 16'h0000, {13'b0, status});
        seen_adr.delete();
        seen_dat.delete();
        rst_n <= 1'b1;
    endtask

    task automatic check_first_fetch();
        @(posedge clk);
        while (!wb_stb) @(posedge clk);
        assert (wb_adr == '0)
            else report_mismatch("first fetch address", 16'h0000, {8'h00, wb_adr});
        assert (!wb_we) else report_fault("first bus cycle after reset is a write");
        assert (status == 3'b000)
            else report_mismatch("status at first fetch", 16'h0000, {13'b0, status});
    endtask

    task automatic run_test(input int t);
        int first;
        int i;
        cur_test = t_name[t];
        load_memory(t);
        apply_reset();
        if (t_abort[t] != 0) begin
            check_first_fetch();
            // cut the program off once a flag is set
            while (status == 3'b000) @(posedge clk);
            repeat (2) @(posedge clk);
            assert (!halted) else report_fault("program halted before the mid-run reset");
            apply_reset();
        end
        check_first_fetch();
        while (!halted) @(posedge clk);
        repeat (settle_cycles) @(posedge clk);
        assert (seen_adr.size() == t_store_cnt[t])
            else report_mismatch("store count", t_store_cnt[t], seen_adr.size());
        first = t_store_first[t];
        for (i = 0; i < t_store_cnt[t]; i++) begin
            assert (seen_adr[i] == exp_adr[first + i])
                else report_mismatch($sformatf("store %0d address", i),
                                     {8'h00, exp_adr[first + i]}, {8'h00, seen_adr[i]});
            assert (seen_dat[i] == exp_dat[first + i])
                else report_mismatch($sformatf("store %0d data", i),
                                     exp_dat[first + i], seen_dat[i]);
        end
        assert (status == t_flags[t])
            else report_mismatch("status flags", {13'b0, t_flags[t]}, {13'b0, status});
        $display("test %s done, %0d stores", cur_test, t_store_cnt[t]);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        wb_dat_i    = '0;
        wb_ack      = 1'b0;
        pending     = 1'b0;
        wait_left   = 2'd0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        cur_test    = "setup";
        rst_q       = 1'b0;
        read_tests();
        // a mid-run reset runs the program twice
        foreach (t_name[t]) begin
            cycle_limit += cycles_per_word * t_prog_cnt[t] * ((t_abort[t] != 0) ? 2 : 1);
        end
        foreach (t_name[t]) begin
            run_test(t);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: logic/risc_cpu.sv
`timescale 1ns/1ps

module risc_cpu import risc_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [data_w-1:0] wb_dat_i,
    input  logic              wb_ack,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output logic [addr_w-1:0] wb_adr,
    output logic [data_w-1:0] wb_dat_o,
    output logic              halted,
    output logic [2:0]        status
);

    logic [data_w-1:0] instr;
    logic [data_w-1:0] c_out;
    logic [data_w-1:0] b_out;
    logic              fetch_req;
    logic              store_req;
    logic              load_ir;
    logic              load_pc;
    logic              clear_pc;
    logic              load_addr;
    logic              ack;

    dp_ctrl_if i_dp_ctrl ();

    controller i_controller (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .ack       (ack),
        .fetch_req (fetch_req),
        .store_req (store_req),
        .load_ir   (load_ir),
        .load_pc   (load_pc),
        .clear_pc  (clear_pc),
        .load_addr (load_addr),
        .halted    (halted),
        .dp_ctrl   (i_dp_ctrl.ctrl)
    );

    bus_unit i_bus_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .store_req (store_req),
        .load_ir   (load_ir),
        .load_pc   (load_pc),
        .clear_pc  (clear_pc),
        .load_addr (load_addr),
        .c_out     (c_out),
        .b_out     (b_out),
        .wb_dat_i  (wb_dat_i),
        .wb_ack    (wb_ack),
        .instr     (instr),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_o  (wb_dat_o),
        .ack       (ack)
    );

    datapath i_datapath (
        .clk     (clk),
        .rst_n   (rst_n),
        .instr   (instr),
        .dp_ctrl (i_dp_ctrl.dp),
        .c_out   (c_out),
        .b_out   (b_out),
        .status  (status)
    );

endmodule

// File: logic/controller.sv
`timescale 1ns/1ps

module controller import risc_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [data_w-1:0] instr,
    input  logic              ack,
    output logic              fetch_req,
    output logic              store_req,
    output logic              load_ir,
    output logic              load_pc,
    output logic              clear_pc,
    output logic              load_addr,
    output logic              halted,
    dp_ctrl_if.ctrl           dp_ctrl
);

    state_t  state;
    state_t  state_nxt;
    opcode_t opcode;
    alu_op_t alu_op;

    assign opcode = instr_opcode(instr);
    assign alu_op = instr_alu_op(instr);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state register and transitions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_rst;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            s_rst:    state_nxt = s_fetch;
            // wait here until the memory answers
            s_fetch:  state_nxt = ack ? s_decode : s_fetch;
            s_decode: begin
                case (opcode)
                    op_alu: begin
                        case (alu_op)
                            alu_add: state_nxt = s_add1;
                            alu_cmp: state_nxt = s_cmp1;
                            alu_and: state_nxt = s_and1;
                            default: state_nxt = s_mvn1;
                        endcase
                    end
                    op_mov: begin
                        if (alu_op == mov_imm) begin
                            state_nxt = s_movi;
                        end else if (alu_op == mov_reg) begin
                            state_nxt = s_movr1;
                        end else begin
                            state_nxt = s_fetch;
                        end
                    end
                    op_str:  state_nxt = s_str1;
                    op_halt: state_nxt = s_halt;
                    default: state_nxt = s_fetch;
                endcase
            end
            s_movi:   state_nxt = s_fetch;
            s_movr1:  state_nxt = s_movr2;
            s_movr2:  state_nxt = s_movr3;
            s_add1:   state_nxt = s_add2;
            s_add2:   state_nxt = s_add3;
            s_add3:   state_nxt = s_add4;
            s_cmp1:   state_nxt = s_cmp2;
            s_cmp2:   state_nxt = s_cmp3;
            s_and1:   state_nxt = s_and2;
            s_and2:   state_nxt = s_and3;
            s_and3:   state_nxt = s_and4;
            s_mvn1:   state_nxt = s_mvn2;
            s_mvn2:   state_nxt = s_mvn3;
            s_str1:   state_nxt = s_str2;
            s_str2:   state_nxt = s_str3;
            s_str3:   state_nxt = s_str4;
            s_str4:   state_nxt = ack ? s_fetch : s_str4;
            s_halt:   state_nxt = s_halt;
            s_movr3, s_add4, s_cmp3, s_and4, s_mvn3: state_nxt = s_fetch;
            default:  state_nxt = s_rst;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // moore outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        dp_ctrl.reg_sel   = sel_rm;
        dp_ctrl.wb_sel    = wb_c;
        dp_ctrl.w_en      = 1'b0;
        dp_ctrl.en_a      = 1'b0;
        dp_ctrl.en_b      = 1'b0;
        dp_ctrl.en_c      = 1'b0;
        dp_ctrl.en_status = 1'b0;
        dp_ctrl.sel_a     = 1'b0;
        dp_ctrl.sel_b     = 1'b0;
        case (state)
            // first operand from Rn
            s_add1, s_cmp1, s_and1, s_str1: begin
                dp_ctrl.reg_sel = sel_rn;
                dp_ctrl.en_a    = 1'b1;
            end
            // second operand from Rm
            s_add2, s_cmp2, s_and2, s_movr1, s_mvn1: begin
                dp_ctrl.reg_sel = sel_rm;
                dp_ctrl.en_b    = 1'b1;
            end
            s_add3, s_and3: dp_ctrl.en_c = 1'b1;
            // B alone, A forced to zero
            s_movr2, s_mvn2: begin
                dp_ctrl.sel_a = 1'b1;
                dp_ctrl.en_c  = 1'b1;
            end
            s_add4, s_and4, s_movr3, s_mvn3: begin
                dp_ctrl.reg_sel = sel_rd;
                dp_ctrl.w_en    = 1'b1;
            end
            s_movi: begin
                dp_ctrl.reg_sel = sel_rn;
                dp_ctrl.wb_sel  = wb_imm;
                dp_ctrl.w_en    = 1'b1;
            end
            s_cmp3: dp_ctrl.en_status = 1'b1;
            // address is Rn plus imm5
            s_str2: begin
                dp_ctrl.sel_b = 1'b1;
                dp_ctrl.en_c  = 1'b1;
            end
            // store data from Rd
            s_str3: begin
                dp_ctrl.reg_sel = sel_rd;
                dp_ctrl.en_b    = 1'b1;
            end
            default: ;
        endcase
    end

    assign fetch_req = (state == s_rst) || (state == s_fetch);
    assign clear_pc  = (state == s_rst);
    assign load_ir   = (state == s_fetch);
    assign load_pc   = (state == s_fetch);
    assign load_addr = (state == s_str3);
    assign store_req = (state == s_str4);
    assign halted    = (state == s_halt);

    a_wen_status_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(dp_ctrl.w_en && dp_ctrl.en_status)
    );

    // halt is left only through reset
    a_halted_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) halted |=> halted
    );

endmodule

// File: logic/bus_unit.sv
`timescale 1ns/1ps

module bus_unit import risc_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_req,
    input  logic              store_req,
    input  logic              load_ir,
    input  logic              load_pc,
    input  logic              clear_pc,
    input  logic              load_addr,
    input  logic [data_w-1:0] c_out,
    input  logic [data_w-1:0] b_out,
    input  logic [data_w-1:0] wb_dat_i,
    input  logic              wb_ack,
    output logic [data_w-1:0] instr,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output logic [addr_w-1:0] wb_adr,
    output logic [data_w-1:0] wb_dat_o,
    output logic              ack
);

    logic [addr_w-1:0] pc;
    logic [addr_w-1:0] addr_q;
    logic              cyc_q;
    logic              start;

    assign ack   = wb_ack && cyc_q;
    assign start = !cyc_q && (fetch_req || store_req);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (clear_pc) begin
            pc <= '0;
        end else if (load_pc && ack) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_ir && ack) instr <= wb_dat_i;
        if (load_addr) addr_q <= c_out[addr_w-1:0];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wishbone classic master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cyc_q <= 1'b0;
            wb_we <= 1'b0;
        end else if (cyc_q) begin
            if (wb_ack) begin
                cyc_q <= 1'b0;
                wb_we <= 1'b0;
            end
        end else if (start) begin
            cyc_q <= 1'b1;
            wb_we <= store_req;
        end
    end

    // address and data only change between cycles
    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr   <= store_req ? addr_q : (clear_pc ? '0 : pc);
            wb_dat_o <= b_out;
        end
    end

    assign wb_cyc = cyc_q;
    assign wb_stb = cyc_q;

    a_stb_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_we))
    );

endmodule

// File: logic/datapath.sv
`timescale 1ns/1ps

module datapath import risc_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [data_w-1:0] instr,
    dp_ctrl_if.dp             dp_ctrl,
    output logic [data_w-1:0] c_out,
    output logic [data_w-1:0] b_out,
    output logic [2:0]        status
);

    logic [reg_aw-1:0] reg_addr;
    logic [data_w-1:0] rd_data;
    logic [data_w-1:0] wr_data;
    logic [data_w-1:0] a_q;
    logic [data_w-1:0] b_q;
    logic [data_w-1:0] c_q;
    logic [data_w-1:0] a_in;
    logic [data_w-1:0] b_in;
    logic [data_w-1:0] imm8_sx;
    logic [data_w-1:0] imm5_sx;
    logic [data_w-1:0] alu_res;
    logic [2:0]        alu_flags;
    shift_t            sh_code;
    alu_op_t           alu_op;

    assign imm8_sx = {{(data_w-8){instr[7]}}, instr[7:0]};
    assign imm5_sx = {{(data_w-5){instr[4]}}, instr[4:0]};

    always_comb begin
        case (dp_ctrl.reg_sel)
            sel_rn:  reg_addr = instr[10:8];
            sel_rd:  reg_addr = instr[7:5];
            default: reg_addr = instr[2:0];
        endcase
    end

    assign wr_data = (dp_ctrl.wb_sel == wb_imm) ? imm8_sx : c_q;

    reg_file i_reg_file (
        .clk    (clk),
        .w_en   (dp_ctrl.w_en),
        .w_addr (reg_addr),
        .r_addr (reg_addr),
        .w_data (wr_data),
        .r_data (rd_data)
    );

    always_ff @(posedge clk) begin
        if (dp_ctrl.en_a) a_q <= rd_data;
        if (dp_ctrl.en_b) b_q <= rd_data;
        if (dp_ctrl.en_c) c_q <= alu_res;
    end

    // STR adds imm5 without a shift
    // the sh bits overlap the immediate
    assign a_in    = dp_ctrl.sel_a ? '0 : a_q;
    assign b_in    = dp_ctrl.sel_b ? imm5_sx : b_q;
    assign sh_code = dp_ctrl.sel_b ? sh_none : shift_t'(instr[4:3]);
    assign alu_op  = dp_ctrl.sel_b ? alu_add : instr_alu_op(instr);

    alu_shifter i_alu_shifter (
        .a      (a_in),
        .b      (b_in),
        .shift  (sh_code),
        .alu_op (alu_op),
        .result (alu_res),
        .flags  (alu_flags)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status <= '0;
        end else if (dp_ctrl.en_status) begin
            status <= alu_flags;
        end
    end

    assign c_out = c_q;
    assign b_out = b_q;

endmodule

// File: logic/alu_shifter.sv
`timescale 1ns/1ps

module alu_shifter import risc_pkg::*; (
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    input  shift_t            shift,
    input  alu_op_t           alu_op,
    output logic [data_w-1:0] result,
    output logic [2:0]        flags
);

    localparam int msb = data_w - 1;

    logic [data_w-1:0] b_sh;
    logic [data_w-1:0] sum;
    logic [data_w-1:0] diff;
    logic              ovf;

    always_comb begin
        case (shift)
            sh_lsl:  b_sh = {b[msb-1:0], 1'b0};
            sh_lsr:  b_sh = {1'b0, b[msb:1]};
            sh_asr:  b_sh = {b[msb], b[msb:1]};
            default: b_sh = b;
        endcase
    end

    assign sum  = a + b_sh;
    assign diff = a - b_sh;

    always_comb begin
        ovf = 1'b0;
        case (alu_op)
            alu_add: begin
                result = sum;
                ovf    = (a[msb] == b_sh[msb]) && (sum[msb] != a[msb]);
            end
            // compare is a minus b
            alu_cmp: begin
                result = diff;
                ovf    = (a[msb] != b_sh[msb]) && (diff[msb] != a[msb]);
            end
            alu_and: result = a & b_sh;
            default: result = ~b_sh;
        endcase
    end

    always_comb begin
        flags         = '0;
        flags[flag_z] = (result == '0);
        flags[flag_n] = result[msb];
        flags[flag_v] = ovf;
    end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import risc_pkg::*; (
    input  logic              clk,
    input  logic              w_en,
    input  logic [reg_aw-1:0] w_addr,
    input  logic [reg_aw-1:0] r_addr,
    input  logic [data_w-1:0] w_data,
    output logic [data_w-1:0] r_data
);

    logic [data_w-1:0] regs [reg_cnt];

    always_ff @(posedge clk) begin
        if (w_en) begin
            regs[w_addr] <= w_data;
        end
    end

    // read is combinational
    assign r_data = regs[r_addr];

endmodule

// File: logic/dp_ctrl_if.sv
`timescale 1ns/1ps

interface dp_ctrl_if import risc_pkg::*; ();

    // register file addressing and write-back
    reg_sel_t reg_sel;
    wb_sel_t  wb_sel;
    logic     w_en;

    // pipeline register loads
    logic     en_a;
    logic     en_b;
    logic     en_c;
    logic     en_status;

    // operand overrides
    logic     sel_a;
    logic     sel_b;

    modport ctrl (
        output reg_sel, wb_sel, w_en,
        output en_a, en_b, en_c, en_status,
        output sel_a, sel_b
    );

    modport dp (
        input reg_sel, wb_sel, w_en,
        input en_a, en_b, en_c, en_status,
        input sel_a, sel_b
    );

endinterface

// File: logic/risc_pkg.sv
package risc_pkg;

    localparam int data_w  = 16;
    localparam int addr_w  = 8;
    localparam int reg_cnt = 8;
    localparam int reg_aw  = $clog2(reg_cnt);

    // bit positions inside the status register
    localparam int flag_z = 0;
    localparam int flag_n = 1;
    localparam int flag_v = 2;

    // op field values of the two MOV forms
    localparam logic [1:0] mov_reg = 2'b00;
    localparam logic [1:0] mov_imm = 2'b10;

    typedef enum logic [2:0] {
        op_str  = 3'b100,
        op_alu  = 3'b101,
        op_mov  = 3'b110,
        op_halt = 3'b111
    } opcode_t;

    typedef enum logic [1:0] {
        alu_add = 2'b00,
        alu_cmp = 2'b01,
        alu_and = 2'b10,
        alu_mvn = 2'b11
    } alu_op_t;

    typedef enum logic [1:0] {
        sh_none = 2'b00,
        sh_lsl  = 2'b01,
        sh_lsr  = 2'b10,
        sh_asr  = 2'b11
    } shift_t;

    typedef enum logic [4:0] {
        s_rst, s_fetch, s_decode, s_halt,
        s_movi, s_movr1, s_movr2, s_movr3,
        s_add1, s_add2, s_add3, s_add4,
        s_cmp1, s_cmp2, s_cmp3,
        s_and1, s_and2, s_and3, s_and4,
        s_mvn1, s_mvn2, s_mvn3,
        s_str1, s_str2, s_str3, s_str4
    } state_t;

    typedef enum logic [1:0] {
        sel_rm = 2'b00,
        sel_rd = 2'b01,
        sel_rn = 2'b10
    } reg_sel_t;

    typedef enum logic [1:0] {
        wb_c   = 2'b00,
        wb_imm = 2'b10
    } wb_sel_t;

    function automatic opcode_t instr_opcode(input logic [data_w-1:0] instr);
        return opcode_t'(instr[15:13]);
    endfunction

    function automatic alu_op_t instr_alu_op(input logic [data_w-1:0] instr);
        return alu_op_t'(instr[12:11]);
    endfunction

endpackage
